//--- source/crop_pkg.sv
`default_nettype none

package crop_pkg;

	// pixel and line counts, offsets
	localparam int CNT_W = 12;

	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [1:0]       res_t; // hires / shires
	typedef logic [7:0]       kbd_t; // keyboard or mouse byte
	typedef logic [6:0]       flg_t; // screen change counter

	// type field value for keyboard codes
	localparam logic [1:0] KBD_TYPE_KEY = 2'd3;

	// amiga raw key codes
	localparam kbd_t KEY_CLEAR    = 8'h41; // backspace
	localparam kbd_t KEY_UP       = 8'h4c;
	localparam kbd_t KEY_DOWN     = 8'h4d;
	localparam kbd_t KEY_RIGHT    = 8'h4e;
	localparam kbd_t KEY_LEFT     = 8'h4f;
	localparam kbd_t KEY_ALT_L    = 8'h64;
	localparam kbd_t KEY_ALT_R    = 8'h65;
	localparam kbd_t KEY_ALT_L_UP = 8'he4; // release codes have bit 7 set
	localparam kbd_t KEY_ALT_R_UP = 8'he5;

	// offset steps per key press
	localparam cnt_t H_STEP = 12'd4;
	localparam cnt_t V_STEP = 12'd1;

	// forced horizontal blank margin
	localparam cnt_t H_FORCE = 12'd8;

	// compare lead, hde comes out later than the counter
	localparam cnt_t H_PIPE = 12'd2;

	// line where forced vblank ends
	localparam cnt_t V_FORCE_END = 12'd2;

endpackage

`default_nettype wire

//--- source/crop_keys.sv
`default_nettype none

module crop_keys import crop_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  kbd_t       kbd_mouse_data,
	input  logic [1:0] kbd_mouse_type,
	input  logic       kbd_mouse_level,

	input  logic       sset,   // load presets
	input  cnt_t       shbl_l,
	input  cnt_t       shbl_r,
	input  cnt_t       svbl_t,
	input  cnt_t       svbl_b,

	output cnt_t       hbl_l,
	output cnt_t       hbl_r,
	output cnt_t       vbl_t,
	output cnt_t       vbl_b
);

	logic old_level;
	logic alt;     // alt held
	logic key_new; // fresh key code this cycle

	// a toggle of the level marks a new byte
	assign key_new = (old_level ^ kbd_mouse_level) && (kbd_mouse_type == KBD_TYPE_KEY);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
		end else begin
			old_level <= kbd_mouse_level;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			alt   <= 1'b0;
			hbl_l <= '0;
			hbl_r <= '0;
			vbl_t <= '0;
			vbl_b <= '0;
		end else begin
			if (key_new) begin
				case (kbd_mouse_data)
					KEY_CLEAR: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					KEY_UP: begin
						if (alt) vbl_b <= vbl_b + V_STEP;
						else     vbl_t <= vbl_t + V_STEP;
					end
					KEY_DOWN: begin
						if (alt) vbl_b <= vbl_b - V_STEP;
						else     vbl_t <= vbl_t - V_STEP;
					end
					KEY_LEFT: begin
						if (alt) hbl_r <= hbl_r + H_STEP; // alt moves the right edge
						else     hbl_l <= hbl_l + H_STEP;
					end
					KEY_RIGHT: begin
						if (alt) hbl_r <= hbl_r - H_STEP;
						else     hbl_l <= hbl_l - H_STEP;
					end
					KEY_ALT_L, KEY_ALT_R:       alt <= 1'b1;
					KEY_ALT_L_UP, KEY_ALT_R_UP: alt <= 1'b0;
					default: ; // other keys pass by
				endcase
			end

			// presets override any key on the same edge
			if (sset) begin
				hbl_l <= shbl_l;
				hbl_r <= shbl_r;
				vbl_t <= svbl_t;
				vbl_b <= svbl_b;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/hblank_gen.sv
`default_nettype none

module hblank_gen import crop_pkg::*; (
	input  logic clk_sys,
	input  logic reset,

	input  logic hs,     // low during sync
	input  logic hblank,
	input  cnt_t vcnt,   // only line 1 matters here
	input  cnt_t hbl_l,
	input  cnt_t hbl_r,

	output logic hbl,    // combined horizontal blank
	output logic hde,
	output cnt_t hsize
);

	logic old_hs;
	logic old_hblank;
	logic hblank_rise;
	logic hblank_fall;

	cnt_t hcnt; // pixels since end of sync
	cnt_t hend; // count where hblank ends
	cnt_t hsta; // count where hblank starts
	cnt_t hmax; // line length

	logic shbl; // user shifted blank
	logic fhbl; // forced blank

	assign hblank_rise = ~old_hblank & hblank;
	assign hblank_fall = old_hblank & ~hblank;

	assign hbl = fhbl | shbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			hcnt       <= '0;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (~hs) hcnt <= '0;
			else     hcnt <= hcnt + 1'b1;
		end
	end

	// edge positions within the line
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hend <= '0;
			hsta <= '0;
			hmax <= '0;
		end else begin
			if (hblank_fall)   hend <= hcnt;
			if (hblank_rise)   hsta <= hcnt;
			if (old_hs & ~hs)  hmax <= hcnt; // sync start ends the line
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
			hde  <= 1'b0;
		end else begin
			if (hcnt == hend + hbl_l - H_PIPE) shbl <= 1'b0;
			if (hcnt == hsta + hbl_r - H_PIPE) shbl <= 1'b1;

			// keep a margin around sync whatever the user offsets are
			if (hcnt == H_FORCE)        fhbl <= 1'b0;
			if (hcnt == hmax - H_FORCE) fhbl <= 1'b1;

			hde <= ~hbl;
		end
	end

	// active width, sampled once per frame
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hsize <= '0;
		end else if (hblank_rise && (vcnt == cnt_t'(1))) begin
			hsize <= hcnt - hend;
		end
	end

endmodule

`default_nettype wire

//--- source/vblank_gen.sv
`default_nettype none

module vblank_gen import crop_pkg::*; (
	input  logic clk_sys,
	input  logic reset,

	input  logic hs,
	input  logic vblank, // vbl or vsync
	input  logic hbl,    // combined horizontal blank
	input  cnt_t vbl_t,
	input  cnt_t vbl_b,  // msb set counts back from vmax

	output cnt_t vcnt,
	output cnt_t vsize,
	output logic vde
);

	logic old_hs;
	logic old_vblank;
	logic old_hbl;
	logic vblank_rise;
	logic vblank_fall;
	logic decide; // blank flags may change now

	cnt_t vend; // line where vblank ends
	cnt_t vmax; // lines per frame
	cnt_t vbot; // line where user blank starts

	logic svbl; // user blank
	logic fvbl; // forced blank

	assign vblank_rise = ~old_vblank & vblank;
	assign vblank_fall = old_vblank & ~vblank;

	// take decisions at the start of active pixels, or anywhere on line 0
	assign decide = (old_hbl & ~hbl) | (vcnt == '0);

	assign vbot = vbl_b[CNT_W-1] ? vmax + vbl_b : vbl_b;

	assign vde = ~(fvbl | svbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_vblank <= 1'b0;
			old_hbl    <= 1'b0;
		end else begin
			old_hs     <= hs;
			old_vblank <= vblank;
			old_hbl    <= hbl;
		end
	end

	// line counter
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vcnt <= '0;
		end else begin
			if (old_hs & ~hs) vcnt <= vcnt + 1'b1;
			if (vblank_rise)  vcnt <= '0; // new frame wins over the hs step
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vend  <= '0;
			vmax  <= '0;
			vsize <= '0;
		end else begin
			if (vblank_fall) vend <= vcnt;

			if (vblank_rise) begin
				vmax  <= vcnt;
				vsize <= vcnt - vend;
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			svbl <= 1'b1;
			fvbl <= 1'b1;
		end else if (decide) begin
			if (vcnt == vend + vbl_t) svbl <= 1'b0;
			if (vcnt == vbot)         svbl <= 1'b1;

			// forced blank around the frame edge
			if (vcnt == vmax - cnt_t'(1)) fvbl <= 1'b1;
			if (vcnt == V_FORCE_END)      fvbl <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/screen_info.sv
`default_nettype none

module screen_info import crop_pkg::*; (
	input  logic clk_sys,
	input  logic reset,

	input  logic vblank,
	input  res_t res,
	input  cnt_t hbl_l,
	input  cnt_t hbl_r,
	input  cnt_t vbl_t,
	input  cnt_t vbl_b,
	input  cnt_t hsize,
	input  cnt_t vsize,

	output cnt_t scr_hbl_l,
	output cnt_t scr_hbl_r,
	output cnt_t scr_vbl_t,
	output cnt_t scr_vbl_b,
	output cnt_t scr_hsize,
	output cnt_t scr_vsize,
	output res_t scr_res,
	output flg_t scr_flg  // steps on each mode change
);

	logic old_vblank;
	logic take;       // end of vertical blank
	logic mode_diff;

	assign take = old_vblank & ~vblank;

	// offsets alone do not count as a mode change
	assign mode_diff = (scr_res != res) || (scr_hsize != hsize) || (scr_vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b0;
			scr_hbl_l  <= '0;
			scr_hbl_r  <= '0;
			scr_vbl_t  <= '0;
			scr_vbl_b  <= '0;
			scr_hsize  <= '0;
			scr_vsize  <= '0;
			scr_res    <= '0;
			scr_flg    <= '0;
		end else begin
			old_vblank <= vblank;

			if (take) begin
				scr_hbl_l <= hbl_l;
				scr_hbl_r <= hbl_r;
				scr_vbl_t <= vbl_t;
				scr_vbl_b <= vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;

				if (mode_diff) scr_flg <= scr_flg + flg_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/video_crop.sv
`default_nettype none

module video_crop import crop_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       hs,      // low during sync
	input  logic       vs,      // low during sync
	input  logic       hblank,
	input  logic       vbl,
	input  res_t       res,

	input  kbd_t       kbd_mouse_data,
	input  logic [1:0] kbd_mouse_type,
	input  logic       kbd_mouse_level,

	input  logic       sset,
	input  cnt_t       shbl_l,
	input  cnt_t       shbl_r,
	input  cnt_t       svbl_t,
	input  cnt_t       svbl_b,

	output logic       hde,
	output logic       vde,

	output cnt_t       scr_hbl_l,
	output cnt_t       scr_hbl_r,
	output cnt_t       scr_vbl_t,
	output cnt_t       scr_vbl_b,
	output cnt_t       scr_hsize,
	output cnt_t       scr_vsize,
	output res_t       scr_res,
	output flg_t       scr_flg
);

	logic vblank; // vsync counts as blank
	logic hbl;
	cnt_t hbl_l, hbl_r, vbl_t, vbl_b;
	cnt_t hsize, vsize;
	cnt_t vcnt;

	assign vblank = vbl | ~vs;

	crop_keys u_keys (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.kbd_mouse_data  (kbd_mouse_data),
		.kbd_mouse_type  (kbd_mouse_type),
		.kbd_mouse_level (kbd_mouse_level),
		.sset            (sset),
		.shbl_l          (shbl_l),
		.shbl_r          (shbl_r),
		.svbl_t          (svbl_t),
		.svbl_b          (svbl_b),
		.hbl_l           (hbl_l),
		.hbl_r           (hbl_r),
		.vbl_t           (vbl_t),
		.vbl_b           (vbl_b)
	);

	hblank_gen u_hblank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.hblank  (hblank),
		.vcnt    (vcnt),
		.hbl_l   (hbl_l),
		.hbl_r   (hbl_r),
		.hbl     (hbl),
		.hde     (hde),
		.hsize   (hsize)
	);

	vblank_gen u_vblank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.vblank  (vblank),
		.hbl     (hbl),
		.vbl_t   (vbl_t),
		.vbl_b   (vbl_b),
		.vcnt    (vcnt),
		.vsize   (vsize),
		.vde     (vde)
	);

	screen_info u_info (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.vblank    (vblank),
		.res       (res),
		.hbl_l     (hbl_l),
		.hbl_r     (hbl_r),
		.vbl_t     (vbl_t),
		.vbl_b     (vbl_b),
		.hsize     (hsize),
		.vsize     (vsize),
		.scr_hbl_l (scr_hbl_l),
		.scr_hbl_r (scr_hbl_r),
		.scr_vbl_t (scr_vbl_t),
		.scr_vbl_b (scr_vbl_b),
		.scr_hsize (scr_hsize),
		.scr_vsize (scr_vsize),
		.scr_res   (scr_res),
		.scr_flg   (scr_flg)
	);

endmodule

`default_nettype wire

//--- test/video_crop_assertions.sv
`default_nettype none

module video_crop_assertions import crop_pkg::*; (
	input wire  logic clk_sys,
	input wire  logic reset,
	input wire  logic hs,
	input wire  logic hde,
	input wire  logic vde,
	input wire  cnt_t vcnt,
	input wire  cnt_t scr_hbl_l,
	input wire  cnt_t scr_hbl_r,
	input wire  cnt_t scr_vbl_t,
	input wire  cnt_t scr_vbl_b,
	input wire  cnt_t scr_hsize,
	input wire  cnt_t scr_vsize,
	input wire  res_t scr_res,
	input wire  flg_t scr_flg
);

	int fail_count = 0; // failed assertions so far

	// sync is part of the combined blank, so hde drops one cycle later
	hde_low_after_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!hs |=> !hde)
		else begin
			$error("hde high in the cycle after hs was low");
			fail_count++;
		end

	// the mode counter only ever steps up by one
	flg_step_one: assert property (@(posedge clk_sys) disable iff (reset)
		(scr_flg != $past(scr_flg)) |-> (scr_flg == flg_t'($past(scr_flg) + 7'd1)))
		else begin
			$error("scr_flg changed by something other than +1");
			fail_count++;
		end

	// forced vblank covers line 0 once the frame size is known
	vde_low_line0: assert property (@(posedge clk_sys) disable iff (reset)
		(vcnt == '0 && scr_vsize != '0) |-> !vde)
		else begin
			$error("vde high on line 0");
			fail_count++;
		end

	outputs_zero_in_reset: assert property (@(posedge clk_sys)
		reset |-> (!hde && !vde && scr_flg == '0 && scr_res == '0
			&& scr_hbl_l == '0 && scr_hbl_r == '0
			&& scr_vbl_t == '0 && scr_vbl_b == '0
			&& scr_hsize == '0 && scr_vsize == '0))
		else begin
			$error("outputs not zero during reset");
			fail_count++;
		end

endmodule

bind video_crop video_crop_assertions u_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.hs        (hs),
	.hde       (hde),
	.vde       (vde),
	.vcnt      (vcnt),
	.scr_hbl_l (scr_hbl_l),
	.scr_hbl_r (scr_hbl_r),
	.scr_vbl_t (scr_vbl_t),
	.scr_vbl_b (scr_vbl_b),
	.scr_hsize (scr_hsize),
	.scr_vsize (scr_vsize),
	.scr_res   (scr_res),
	.scr_flg   (scr_flg)
);

`default_nettype wire

//--- test/tb_video_crop.sv
`default_nettype none

module tb_video_crop import crop_pkg::*; ();

	localparam int LINE_LEN   = 100;
	localparam int HS_LEN     = 8;
	localparam int HBL_LEN    = 20;
	localparam int FRAME_LEN  = 40;
	localparam int VBL_LINES  = 6;
	localparam int WAIT_LIMIT = 6000; // a bit more than one frame

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       hs, vs, hblank, vbl;
	res_t       res;
	kbd_t       kbd_mouse_data;
	logic [1:0] kbd_mouse_type;
	logic       kbd_mouse_level;
	logic       sset;
	cnt_t       shbl_l, shbl_r, svbl_t, svbl_b;

	wire logic hde, vde;
	wire cnt_t scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b, scr_hsize, scr_vsize;
	wire res_t scr_res;
	wire flg_t scr_flg;

	// offset model
	cnt_t m_hbl_l, m_hbl_r, m_vbl_t, m_vbl_b;
	logic m_alt;
	flg_t flg0;
	int   pix, line;
	int   seed;
	int   idx;
	kbd_t codes [0:8];

	video_crop UUT (.*);

	always #20 clk_sys = ~clk_sys;

	// progressive timing generator
	always @(posedge clk_sys) begin
		hs     <= (pix >= HS_LEN);
		hblank <= (pix < HBL_LEN);
		vs     <= (line != 0);
		vbl    <= (line < VBL_LINES);
		if (reset) begin
			pix  <= 0;
			line <= 0;
		end else if (pix == LINE_LEN - 1) begin
			pix  <= 0;
			line <= (line == FRAME_LEN - 1) ? 0 : line + 1;
		end else begin
			pix <= pix + 1;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// returns a few cycles after the end of the next vertical blank
	task automatic wait_snapshot();
		int n;
		n = 0;
		while (!vbl) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) timeout_fail("vbl to rise");
		end
		n = 0;
		while (vbl) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) timeout_fail("vbl to fall");
		end
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_snapshot();
		check_val("scr_hbl_l", 32'(scr_hbl_l), 32'(m_hbl_l));
		check_val("scr_hbl_r", 32'(scr_hbl_r), 32'(m_hbl_r));
		check_val("scr_vbl_t", 32'(scr_vbl_t), 32'(m_vbl_t));
		check_val("scr_vbl_b", 32'(scr_vbl_b), 32'(m_vbl_b));
		check_val("scr_hsize", 32'(scr_hsize), LINE_LEN - HBL_LEN);
		check_val("scr_vsize", 32'(scr_vsize), FRAME_LEN - VBL_LINES);
		check_val("scr_res", 32'(scr_res), 32'(res));
	endtask

	// follows the key rules on the model
	task automatic model_key(input kbd_t code);
		case (code)
			KEY_CLEAR: begin
				m_hbl_l = '0;
				m_hbl_r = '0;
				m_vbl_t = '0;
				m_vbl_b = '0;
			end
			KEY_UP: begin
				if (m_alt) m_vbl_b += 12'd1;
				else       m_vbl_t += 12'd1;
			end
			KEY_DOWN: begin
				if (m_alt) m_vbl_b -= 12'd1;
				else       m_vbl_t -= 12'd1;
			end
			KEY_LEFT: begin
				if (m_alt) m_hbl_r += 12'd4;
				else       m_hbl_l += 12'd4;
			end
			KEY_RIGHT: begin
				if (m_alt) m_hbl_r -= 12'd4;
				else       m_hbl_l -= 12'd4;
			end
			KEY_ALT_L, KEY_ALT_R:       m_alt = 1'b1;
			KEY_ALT_L_UP, KEY_ALT_R_UP: m_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic send_key(input kbd_t code, input logic [1:0] typ);
		@(posedge clk_sys);
		kbd_mouse_data  <= code;
		kbd_mouse_type  <= typ;
		kbd_mouse_level <= ~kbd_mouse_level;
		if (typ == KBD_TYPE_KEY) model_key(code);
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic random_keys(input int count);
		repeat (count) begin
			idx = ($random(seed) & 32'h7fff) % 9;
			if ((($random(seed) & 32'hff) % 5) == 0) send_key(codes[idx], 2'd2); // ignored
			else send_key(codes[idx], KBD_TYPE_KEY);
		end
	endtask

	initial begin
		codes = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_ALT_L,
			KEY_ALT_L_UP, KEY_ALT_R, KEY_ALT_R_UP, KEY_UP};
		seed            = 32'h1c41;
		reset           = 1'b1;
		hs              = 1'b1;
		vs              = 1'b1;
		hblank          = 1'b0;
		vbl             = 1'b0;
		res             = '0;
		kbd_mouse_data  = '0;
		kbd_mouse_type  = '0;
		kbd_mouse_level = 1'b0;
		sset            = 1'b0;
		shbl_l          = '0;
		shbl_r          = '0;
		svbl_t          = '0;
		svbl_b          = '0;
		m_hbl_l = '0;
		m_hbl_r = '0;
		m_vbl_t = '0;
		m_vbl_b = '0;
		m_alt   = 1'b0;

		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_val("scr_flg", 32'(scr_flg), 0);
		check_val("hde", 32'(hde), 0);
		check_val("vde", 32'(vde), 0);
		check_val("scr_hsize", 32'(scr_hsize), 0);
		check_val("scr_vsize", 32'(scr_vsize), 0);
		check_val("scr_hbl_l", 32'(scr_hbl_l), 0);
		check_val("scr_hbl_r", 32'(scr_hbl_r), 0);
		check_val("scr_vbl_t", 32'(scr_vbl_t), 0);
		check_val("scr_vbl_b", 32'(scr_vbl_b), 0);
		check_val("scr_res", 32'(scr_res), 0);

		// let the measured sizes settle
		repeat (3) wait_snapshot();
		check_snapshot();
		flg0 = scr_flg;
		wait_snapshot();
		check_val("scr_flg", 32'(scr_flg), 32'(flg0));

		random_keys(24);
		wait_snapshot();
		check_snapshot();
		random_keys(24);
		wait_snapshot();
		check_snapshot();

		send_key(KEY_CLEAR, KBD_TYPE_KEY);
		wait_snapshot();
		check_snapshot();

		// presets win over a key on the same edge
		@(posedge clk_sys);
		shbl_l          <= 12'd8;
		shbl_r          <= 12'hffc;
		svbl_t          <= 12'd3;
		svbl_b          <= 12'hffe;
		sset            <= 1'b1;
		kbd_mouse_data  <= KEY_LEFT;
		kbd_mouse_type  <= KBD_TYPE_KEY;
		kbd_mouse_level <= ~kbd_mouse_level;
		@(posedge clk_sys);
		sset    <= 1'b0;
		m_hbl_l = 12'd8;
		m_hbl_r = 12'hffc;
		m_vbl_t = 12'd3;
		m_vbl_b = 12'hffe;
		wait_snapshot();
		check_snapshot();
		check_val("scr_flg", 32'(scr_flg), 32'(flg0));

		@(posedge clk_sys);
		res <= 2'd1;
		wait_snapshot();
		check_snapshot();
		check_val("scr_flg", 32'(scr_flg), 32'(flg_t'(flg0 + 7'd1)));
		wait_snapshot();
		check_val("scr_flg", 32'(scr_flg), 32'(flg_t'(flg0 + 7'd1)));

		if (UUT.u_assert.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("%0d assertion checks failed", UUT.u_assert.fail_count);
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
source/crop_pkg.sv
source/crop_keys.sv
source/hblank_gen.sv
source/vblank_gen.sv
source/screen_info.sv
source/video_crop.sv
test/video_crop_assertions.sv
test/tb_video_crop.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_crop
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
